/* miriscv_lite.f */
logic/miriscv_pkg.sv
logic/miriscv_fetch.sv
logic/miriscv_decode.sv
logic/miriscv_alu.sv
logic/miriscv_mdu.sv
logic/miriscv_writeback.sv
logic/miriscv_core.sv
verification/miriscv_core_tb.sv

/* Makefile */
# Verilator flow for miriscv_lite

VERILATOR  ?= verilator
FILELIST   ?= miriscv_lite.f
TB_TOP     ?= miriscv_core_tb
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)

# A $fatal in the testbench gives a failing exit status
sim:
	$(VERILATOR) --binary --timing $(SIM_FLAGS) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)

/* verification/miriscv_core_tb.sv */
// Testbench of the miriscv_lite core
//  - clock, reset and DUT instance
//  - instruction memory model with random answer latency
//  - program table with expected retire reports, applied in a loop
//  - compare and abort helpers

`timescale 1ns/10ps

module miriscv_core_tb;
  import miriscv_pkg::*;

  localparam logic [XLEN-1:0] BOOT_ADDR      = 32'h0000_0100;
  localparam int unsigned     REQ_TIMEOUT    = 20;
  localparam int unsigned     RETIRE_TIMEOUT = 20;
  localparam logic [16:0]     LFSR_SEED      = 17'd66453;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;

  typedef struct packed {
    logic [ILEN-1:0]       insn;
    logic [GPR_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       wdata;
    logic                  trap;
  } prog_entry_t;

  logic            clk;
  logic            arst_n;
  logic            instr_rvalid;
  logic [ILEN-1:0] instr_rdata;
  logic            instr_req;
  logic [XLEN-1:0] instr_addr;
  retire_t         retire;

  logic [16:0]     lfsr_q;
  prog_entry_t     prog_q [$];

  miriscv_core #(
    .BOOT_ADDR ( BOOT_ADDR )
  ) miriscv_core_inst (
    .clk_i          ( clk          ),
    .arst_n_i       ( arst_n       ),
    .instr_rvalid_i ( instr_rvalid ),
    .instr_rdata_i  ( instr_rdata  ),
    .instr_req_o    ( instr_req    ),
    .instr_addr_o   ( instr_addr   ),
    .retire_o       ( retire       )
  );

  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  function automatic logic [16:0] lfsr_next(input logic [16:0] state);
    lfsr_next = {state[15:0], state[16] ^ state[13]}; // x^17 + x^14 + 1
  endfunction

  // Memory latency of 0 to 3 cycles
  task automatic draw_delay(output int unsigned delay);
    logic [1:0]  bits;
    int unsigned b;
    for (b = 0; b < 2; b++) begin
      lfsr_q  = lfsr_next(lfsr_q);
      bits[b] = lfsr_q[0];
    end
    delay = {30'b0, bits};
  endtask

  function automatic logic [ILEN-1:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
    enc_r = {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [ILEN-1:0] enc_i(input logic [6:0] opc, input logic [11:0] imm,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
    enc_i = {imm, rs1, f3, rd, opc};
  endfunction

  task automatic add_op(input logic [ILEN-1:0] insn, input logic [XLEN-1:0] wdata,
                        input logic trap);
    prog_entry_t entry;
    entry = '{insn: insn, rd: insn[11:7], wdata: wdata, trap: trap};
    prog_q.push_back(entry);
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH %s: got 0x%08h, expected 0x%08h", name, actual, expected));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Instruction port and retire

  task automatic wait_for_request();
    int unsigned cycles;
    cycles = 0;
    while (!instr_req) begin
      @(negedge clk);
      cycles++;
      if (retire.valid) abort_run("retire_o.valid stayed high after its retire cycle");
      if (cycles > REQ_TIMEOUT) abort_run("Timed out waiting for instr_req_o");
    end
  endtask

  // Counts cycles from the rvalid cycle to retire_o.valid
  task automatic wait_for_retire(output int unsigned cycles);
    cycles = 0;
    do begin
      @(negedge clk);
      instr_rvalid = 1'b0; // One-cycle answer
      cycles++;
      if (instr_req) abort_run("instr_req_o raised before the fetched instruction retired");
      if (cycles > RETIRE_TIMEOUT) abort_run("Timed out waiting for retire_o.valid");
    end while (!retire.valid);
  endtask

  task automatic run_entry(input prog_entry_t entry, input logic [XLEN-1:0] exp_addr);
    int unsigned delay;
    int unsigned cycles;
    int unsigned d;
    wait_for_request();
    check_value("instr_addr_o", instr_addr, exp_addr);
    draw_delay(delay);
    for (d = 0; d < delay; d++) begin
      @(negedge clk);
      if (instr_req) abort_run("instr_req_o raised again while a request was outstanding");
    end
    instr_rvalid = 1'b1;
    instr_rdata  = entry.insn;
    wait_for_retire(cycles);
    check_value("retire_o.valid latency", cycles, 32'd3);
    check_value("retire_o.pc", retire.pc, exp_addr);
    check_value("retire_o.insn", retire.insn, entry.insn);
    check_value("retire_o.rd_addr", 32'(retire.rd_addr), 32'(entry.rd));
    check_value("retire_o.rd_wdata", retire.rd_wdata, entry.wdata);
    check_value("retire_o.trap", 32'(retire.trap), 32'(entry.trap));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Program table with results that follow from the entries above each line

  task automatic load_program();
    add_op(enc_i(OPC_OP_IMM, 12'h005, 5'd0, 3'h0, 5'd1), 32'h0000_0005, 1'b0); // addi x1,x0,5
    add_op(enc_i(OPC_OP_IMM, 12'hFFD, 5'd0, 3'h0, 5'd2), 32'hFFFF_FFFD, 1'b0); // addi x2,x0,-3
    add_op(enc_r(7'h00, 5'd2, 5'd1, 3'h0, 5'd3), 32'h0000_0002, 1'b0);  // add x3,x1,x2
    add_op(enc_r(7'h20, 5'd2, 5'd1, 3'h0, 5'd4), 32'h0000_0008, 1'b0);  // sub x4,x1,x2
    add_op(enc_i(OPC_OP_IMM, 12'h0F0, 5'd2, 3'h4, 5'd5), 32'hFFFF_FF0D, 1'b0); // xori
    add_op(enc_i(OPC_OP_IMM, 12'hFF0, 5'd1, 3'h6, 5'd6), 32'hFFFF_FFF5, 1'b0); // ori -16
    add_op(enc_i(OPC_OP_IMM, 12'h07F, 5'd2, 3'h7, 5'd7), 32'h0000_007D, 1'b0); // andi
    add_op(enc_i(OPC_OP_IMM, 12'h001, 5'd2, 3'h2, 5'd8), 32'h0000_0001, 1'b0); // slti
    add_op(enc_i(OPC_OP_IMM, 12'h001, 5'd2, 3'h3, 5'd9), 32'h0000_0000, 1'b0); // sltiu
    add_op(enc_i(OPC_OP_IMM, 12'h01C, 5'd1, 3'h1, 5'd10), 32'h5000_0000, 1'b0); // slli 28
    add_op(enc_i(OPC_OP_IMM, 12'h004, 5'd2, 3'h5, 5'd11), 32'h0FFF_FFFF, 1'b0); // srli 4
    add_op(enc_i(OPC_OP_IMM, 12'h401, 5'd2, 3'h5, 5'd12), 32'hFFFF_FFFE, 1'b0); // srai 1
    add_op(enc_r(7'h00, 5'd4, 5'd1, 3'h1, 5'd13), 32'h0000_0500, 1'b0);   // sll x13,x1,x4
    add_op(enc_r(7'h00, 5'd1, 5'd2, 3'h5, 5'd14), 32'h07FF_FFFF, 1'b0);   // srl x14,x2,x1
    add_op(enc_r(7'h20, 5'd1, 5'd2, 3'h5, 5'd15), 32'hFFFF_FFFF, 1'b0);   // sra x15,x2,x1
    add_op(enc_r(7'h00, 5'd1, 5'd2, 3'h2, 5'd16), 32'h0000_0001, 1'b0);   // slt x16,x2,x1
    add_op(enc_r(7'h00, 5'd1, 5'd2, 3'h3, 5'd17), 32'h0000_0000, 1'b0);   // sltu x17,x2,x1
    add_op(enc_r(7'h00, 5'd6, 5'd5, 3'h7, 5'd18), 32'hFFFF_FF05, 1'b0);   // and x18,x5,x6
    add_op(enc_r(7'h00, 5'd10, 5'd7, 3'h6, 5'd19), 32'h5000_007D, 1'b0);  // or x19,x7,x10
    add_op(enc_r(7'h00, 5'd12, 5'd11, 3'h4, 5'd20), 32'hF000_0001, 1'b0); // xor x20,x11,x12
    // Multiply with x2 = -3, x4 = 8 and x1 = 5
    add_op(enc_r(7'h01, 5'd4, 5'd2, 3'h0, 5'd21), 32'hFFFF_FFE8, 1'b0);   // mul
    add_op(enc_r(7'h01, 5'd4, 5'd2, 3'h1, 5'd22), 32'hFFFF_FFFF, 1'b0);   // mulh
    add_op(enc_r(7'h01, 5'd4, 5'd2, 3'h3, 5'd23), 32'h0000_0007, 1'b0);   // mulhu
    add_op(enc_r(7'h01, 5'd1, 5'd2, 3'h2, 5'd24), 32'hFFFF_FFFF, 1'b0);   // mulhsu -3 * 5
    add_op(enc_r(7'h01, 5'd2, 5'd1, 3'h2, 5'd25), 32'h0000_0004, 1'b0);   // mulhsu 5 * 2^32-3
    add_op(enc_r(7'h01, 5'd2, 5'd2, 3'h1, 5'd26), 32'h0000_0000, 1'b0);   // mulh -3 * -3
    add_op(enc_r(7'h01, 5'd2, 5'd2, 3'h3, 5'd27), 32'hFFFF_FFFA, 1'b0);   // mulhu
    add_op(enc_r(7'h01, 5'd2, 5'd2, 3'h0, 5'd28), 32'h0000_0009, 1'b0);   // mul
    // x0 writes, a load and a divide
    add_op(enc_i(OPC_OP_IMM, 12'h007, 5'd1, 3'h0, 5'd0), 32'h0000_0000, 1'b0); // addi x0
    add_op(enc_r(7'h00, 5'd1, 5'd0, 3'h0, 5'd29), 32'h0000_0005, 1'b0);   // add x29,x0,x1
    add_op(enc_i(OPC_LOAD, 12'h000, 5'd2, 3'h2, 5'd29), 32'h0000_0000, 1'b1); // lw x29
    add_op(enc_i(OPC_OP_IMM, 12'h001, 5'd29, 3'h0, 5'd30), 32'h0000_0006, 1'b0); // x29 kept
    add_op(enc_r(7'h01, 5'd2, 5'd1, 3'h4, 5'd31), 32'h0000_0000, 1'b1);   // div
    add_op(enc_r(7'h00, 5'd1, 5'd31, 3'h6, 5'd31), 32'h0000_0005, 1'b0);  // or x31,x31,x1
  endtask

  initial begin
    logic [XLEN-1:0] next_addr;
    int unsigned     idx;
    clk          = 1'b0;
    arst_n       = 1'b0;
    instr_rvalid = 1'b0;
    instr_rdata  = '0;
    lfsr_q       = LFSR_SEED;
    next_addr    = BOOT_ADDR;
    load_program();
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    for (idx = 0; idx < prog_q.size(); idx++) begin
      run_entry(prog_q[idx], next_addr);
      next_addr = next_addr + 32'd4;
    end
    $display("No errors");
    $finish;
  end

endmodule

/* logic/miriscv_core.sv */
// miriscv_lite core top level
//  - fetch, decode, ALU, multiply and writeback units
//  - request/valid instruction port and retire report

`timescale 1ns/10ps

module miriscv_core #(
  parameter logic [miriscv_pkg::XLEN-1:0] BOOT_ADDR = '0
) (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic                         instr_rvalid_i,
  input  logic [miriscv_pkg::ILEN-1:0] instr_rdata_i,
  output logic                         instr_req_o,
  output logic [miriscv_pkg::XLEN-1:0] instr_addr_o,
  output miriscv_pkg::retire_t         retire_o
);
  import miriscv_pkg::*;

  fetch_t          fetch;
  decoded_t        decoded;
  gpr_wr_t         gpr_wr;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] mdu_result;

  miriscv_fetch #(
    .BOOT_ADDR ( BOOT_ADDR )
  ) i_fetch (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .retire_valid_i ( retire_o.valid ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .fetch_o        ( fetch          )
  );

  miriscv_decode i_decode (
    .clk_i     ( clk_i    ),
    .arst_n_i  ( arst_n_i ),
    .fetch_i   ( fetch    ),
    .gpr_wr_i  ( gpr_wr   ),
    .decoded_o ( decoded  )
  );

  // Both units see the same operands, writeback picks one
  miriscv_alu i_alu (
    .op1_i    ( decoded.op1    ),
    .op2_i    ( decoded.op2    ),
    .alu_op_i ( decoded.alu_op ),
    .result_o ( alu_result     )
  );

  miriscv_mdu i_mdu (
    .op1_i    ( decoded.op1    ),
    .op2_i    ( decoded.op2    ),
    .mdu_op_i ( decoded.mdu_op ),
    .result_o ( mdu_result     )
  );

  miriscv_writeback i_writeback (
    .clk_i        ( clk_i      ),
    .arst_n_i     ( arst_n_i   ),
    .decoded_i    ( decoded    ),
    .alu_result_i ( alu_result ),
    .mdu_result_i ( mdu_result ),
    .gpr_wr_o     ( gpr_wr     ),
    .retire_o     ( retire_o   )
  );

endmodule

/* logic/miriscv_writeback.sv */
// Writeback unit
//  - ALU or multiply result select
//  - register file write port
//  - retire report register

`timescale 1ns/10ps

module miriscv_writeback (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  miriscv_pkg::decoded_t        decoded_i,
  input  logic [miriscv_pkg::XLEN-1:0] alu_result_i,
  input  logic [miriscv_pkg::XLEN-1:0] mdu_result_i,
  output miriscv_pkg::gpr_wr_t         gpr_wr_o,
  output miriscv_pkg::retire_t         retire_o
);
  import miriscv_pkg::*;

  logic [XLEN-1:0] result;
  logic            wr_en;
  retire_t         retire_d;
  retire_t         retire_q;
  logic            retire_valid_q;

  assign result = decoded_i.use_mdu ? mdu_result_i : alu_result_i;
  assign wr_en  = decoded_i.valid & decoded_i.rd_we;

  // Written on the same edge that registers the retire report
  assign gpr_wr_o = '{we: wr_en, addr: decoded_i.rd_addr, data: result};

  always_comb begin
    retire_d.valid    = decoded_i.valid;
    retire_d.trap     = decoded_i.trap;
    retire_d.pc       = decoded_i.pc;
    retire_d.insn     = decoded_i.insn;
    retire_d.rd_addr  = decoded_i.rd_addr;
    retire_d.rd_wdata = decoded_i.rd_we ? result : '0; // Traps and x0 report zero
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) retire_valid_q <= 1'b0;
    else           retire_valid_q <= decoded_i.valid;
  end

  always_ff @(posedge clk_i) begin
    if (decoded_i.valid) retire_q <= retire_d;
  end

  always_comb begin
    retire_o       = retire_q;
    retire_o.valid = retire_valid_q;
  end

endmodule

/* logic/miriscv_mdu.sv */
// Multiply unit
//  - MUL, MULH, MULHSU, MULHU
//  - one signed 33x33 product covers every signedness mix

`timescale 1ns/10ps

module miriscv_mdu (
  input  logic [miriscv_pkg::XLEN-1:0] op1_i,
  input  logic [miriscv_pkg::XLEN-1:0] op2_i,
  input  miriscv_pkg::mdu_op_e         mdu_op_i,
  output logic [miriscv_pkg::XLEN-1:0] result_o
);
  import miriscv_pkg::*;

  logic                   op1_signed;
  logic                   op2_signed;
  logic signed [XLEN:0]   op1_ext;
  logic signed [XLEN:0]   op2_ext;
  logic signed [2*XLEN-1:0] product;

  always_comb begin
    case (mdu_op_i)
      MDU_MULH: begin
        op1_signed = 1'b1;
        op2_signed = 1'b1;
      end
      MDU_MULHSU: begin
        op1_signed = 1'b1;
        op2_signed = 1'b0;
      end
      MDU_MULHU: begin
        op1_signed = 1'b0;
        op2_signed = 1'b0;
      end
      default: begin // Low word is the same for any signedness
        op1_signed = 1'b1;
        op2_signed = 1'b1;
      end
    endcase
  end

  assign op1_ext = {op1_signed & op1_i[XLEN-1], op1_i};
  assign op2_ext = {op2_signed & op2_i[XLEN-1], op2_i};

  // Truncated to 64 bits, exact for 33-bit signed operands
  assign product = (2*XLEN)'(op1_ext) * (2*XLEN)'(op2_ext);

  assign result_o = (mdu_op_i == MDU_MUL) ? product[XLEN-1:0] : product[2*XLEN-1:XLEN];

endmodule

/* logic/miriscv_alu.sv */
// Integer ALU
//  - add and subtract
//  - AND, OR, XOR
//  - logical and arithmetic shifts
//  - signed and unsigned set-less-than

`timescale 1ns/10ps

module miriscv_alu (
  input  logic [miriscv_pkg::XLEN-1:0] op1_i,
  input  logic [miriscv_pkg::XLEN-1:0] op2_i,
  input  miriscv_pkg::alu_op_e         alu_op_i,
  output logic [miriscv_pkg::XLEN-1:0] result_o
);
  import miriscv_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = op2_i[4:0];
  assign lt_signed   = $signed(op1_i) < $signed(op2_i);
  assign lt_unsigned = op1_i < op2_i;

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  result_o = op1_i + op2_i;
      ALU_SUB:  result_o = op1_i - op2_i;
      ALU_AND:  result_o = op1_i & op2_i;
      ALU_OR:   result_o = op1_i | op2_i;
      ALU_XOR:  result_o = op1_i ^ op2_i;
      ALU_SLL:  result_o = op1_i << shamt;
      ALU_SRL:  result_o = op1_i >> shamt;
      ALU_SRA:  result_o = $unsigned($signed(op1_i) >>> shamt);
      ALU_SLT:  result_o = XLEN'(lt_signed);
      ALU_SLTU: result_o = XLEN'(lt_unsigned);
      default:  result_o = '0;
    endcase
  end

endmodule

/* logic/miriscv_decode.sv */
// Decode unit
//  - 32-entry register file, written from writeback
//  - R-type and I-type decoding to ALU or multiply operations
//  - trap marking of unsupported words
//  - decoded-operation register

`timescale 1ns/10ps

module miriscv_decode (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  miriscv_pkg::fetch_t   fetch_i,
  input  miriscv_pkg::gpr_wr_t  gpr_wr_i,
  output miriscv_pkg::decoded_t decoded_o
);
  import miriscv_pkg::*;

  localparam int GPR_NUM = 2**GPR_ADDR_W;

  logic [XLEN-1:0] gpr_q [GPR_NUM];
  instr_u          insn;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] imm_sext;
  logic            legal;
  decoded_t        dec_d;
  decoded_t        dec_q;
  logic            valid_q;

  // alt picks SUB over ADD and SRA over SRL
  function automatic alu_op_e alu_op_sel(input logic [2:0] funct3, input logic alt);
    case (funct3)
      F3_ADD_SUB: alu_op_sel = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     alu_op_sel = ALU_SLL;
      F3_SLT:     alu_op_sel = ALU_SLT;
      F3_SLTU:    alu_op_sel = ALU_SLTU;
      F3_XOR:     alu_op_sel = ALU_XOR;
      F3_SRL_SRA: alu_op_sel = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      alu_op_sel = ALU_OR;
      default:    alu_op_sel = ALU_AND;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////////////
  // Register file

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpr_q <= '{default: '0};
    end else if (gpr_wr_i.we) begin
      gpr_q[gpr_wr_i.addr] <= gpr_wr_i.data;
    end
  end

  assign insn     = fetch_i.insn;
  assign rs1_data = gpr_q[insn.r.rs1];
  assign rs2_data = gpr_q[insn.r.rs2];
  assign imm_sext = {{(XLEN-12){insn.i.imm12[11]}}, insn.i.imm12};

  //////////////////////////////////////////////////////////////////////////////
  // Decoding

  always_comb begin
    dec_d         = '0;
    dec_d.valid   = fetch_i.valid;
    dec_d.pc      = fetch_i.pc;
    dec_d.insn    = insn;
    dec_d.op1     = rs1_data;
    dec_d.op2     = rs2_data;
    dec_d.alu_op  = ALU_ADD;
    dec_d.mdu_op  = MDU_MUL;
    dec_d.rd_addr = insn.r.rd;
    legal         = 1'b0;
    case (insn.r.opcode)
      OPCODE_OP: begin
        if (insn.r.funct7 == F7_MULDIV) begin
          legal         = ~insn.r.funct3[2]; // no division
          dec_d.use_mdu = 1'b1;
          dec_d.mdu_op  = mdu_op_e'(insn.r.funct3[1:0]);
        end else begin
          legal = (insn.r.funct7 == F7_BASE) ||
                  (insn.r.funct7 == F7_ALT &&
                   (insn.r.funct3 == F3_ADD_SUB || insn.r.funct3 == F3_SRL_SRA));
          dec_d.alu_op = alu_op_sel(insn.r.funct3, insn.r.funct7[5]);
        end
      end
      OPCODE_OP_IMM: begin
        legal        = 1'b1;
        dec_d.op2    = imm_sext;
        dec_d.alu_op = alu_op_sel(insn.i.funct3, 1'b0);
        if (insn.i.funct3 == F3_SLL) begin
          legal     = (insn.i.imm12[11:5] == F7_BASE);
          dec_d.op2 = XLEN'(insn.i.imm12[4:0]);
        end else if (insn.i.funct3 == F3_SRL_SRA) begin
          legal        = (insn.i.imm12[11:5] == F7_BASE) || (insn.i.imm12[11:5] == F7_ALT);
          dec_d.op2    = XLEN'(insn.i.imm12[4:0]);
          dec_d.alu_op = alu_op_sel(insn.i.funct3, insn.i.imm12[10]);
        end
      end
      default: ;
    endcase
    dec_d.trap  = ~legal;
    dec_d.rd_we = legal && (insn.r.rd != '0); // x0 stays zero
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) valid_q <= 1'b0;
    else           valid_q <= fetch_i.valid;
  end

  always_ff @(posedge clk_i) begin
    if (fetch_i.valid) dec_q <= dec_d;
  end

  always_comb begin
    decoded_o       = dec_q;
    decoded_o.valid = valid_q;
  end

endmodule

/* logic/miriscv_fetch.sv */
// Fetch unit
//  - program counter, starts at BOOT_ADDR
//  - one-cycle request on the instruction port, one request outstanding
//  - fetched word held for decode, PC advanced on retire

`timescale 1ns/10ps

module miriscv_fetch #(
  parameter logic [miriscv_pkg::XLEN-1:0] BOOT_ADDR = '0
) (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic                         instr_rvalid_i,
  input  miriscv_pkg::instr_u          instr_rdata_i,
  input  logic                         retire_valid_i,
  output logic                         instr_req_o,
  output logic [miriscv_pkg::XLEN-1:0] instr_addr_o,
  output miriscv_pkg::fetch_t          fetch_o
);
  import miriscv_pkg::*;

  typedef enum logic {ST_IDLE, ST_BUSY} state_e;

  state_e          state_q;
  logic            req_q;
  logic            boot_q;  // First request after reset
  logic            fetch_valid_q;
  logic [XLEN-1:0] pc_q;
  instr_u          insn_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= ST_IDLE;
      req_q         <= 1'b0;
      boot_q        <= 1'b1;
      fetch_valid_q <= 1'b0;
      pc_q          <= BOOT_ADDR;
    end else begin
      req_q         <= 1'b0;
      fetch_valid_q <= 1'b0;
      boot_q        <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (boot_q || retire_valid_i) begin
            req_q   <= 1'b1;
            state_q <= ST_BUSY;
            if (retire_valid_i) pc_q <= pc_q + XLEN'(4);
          end
        end
        ST_BUSY: begin
          if (instr_rvalid_i) begin
            fetch_valid_q <= 1'b1;
            state_q       <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Stray rvalid in ST_IDLE never reaches the word register
  always_ff @(posedge clk_i) begin
    if (state_q == ST_BUSY && instr_rvalid_i) insn_q <= instr_rdata_i;
  end

  assign instr_req_o  = req_q;
  assign instr_addr_o = pc_q;
  assign fetch_o      = '{valid: fetch_valid_q, pc: pc_q, insn: insn_q};

endmodule

/* logic/miriscv_pkg.sv */
// Shared definitions of the miriscv_lite core
//  - word and register address widths
//  - opcode, funct3 and funct7 encodings of the supported instructions
//  - ALU and multiply operation codes
//  - instruction word views and the structs passed between stages

package miriscv_pkg;

  localparam int XLEN       = 32;
  localparam int ILEN       = 32;
  localparam int GPR_ADDR_W = 5;
  localparam int OPCODE_W   = 7;

  localparam logic [OPCODE_W-1:0] OPCODE_OP     = 7'b0110011;
  localparam logic [OPCODE_W-1:0] OPCODE_OP_IMM = 7'b0010011;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;

  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_ALT    = 7'b0100000; // SUB, SRA
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
  } alu_op_e;

  // Same order as funct3 of the M extension
  typedef enum logic [1:0] {
    MDU_MUL, MDU_MULH, MDU_MULHSU, MDU_MULHU
  } mdu_op_e;

  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [GPR_ADDR_W-1:0] rs2;
      logic [GPR_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [GPR_ADDR_W-1:0] rd;
      logic [OPCODE_W-1:0]   opcode;
    } r;
    struct packed {
      logic [11:0]           imm12;
      logic [GPR_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [GPR_ADDR_W-1:0] rd;
      logic [OPCODE_W-1:0]   opcode;
    } i;
  } instr_u;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    instr_u          insn;
  } fetch_t;

  typedef struct packed {
    logic                  valid;
    logic [XLEN-1:0]       pc;
    instr_u                insn;
    logic [XLEN-1:0]       op1;
    logic [XLEN-1:0]       op2;     // rs2 or immediate
    alu_op_e               alu_op;
    mdu_op_e               mdu_op;
    logic                  use_mdu;
    logic [GPR_ADDR_W-1:0] rd_addr;
    logic                  rd_we;
    logic                  trap;
  } decoded_t;

  typedef struct packed {
    logic                  we;
    logic [GPR_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       data;
  } gpr_wr_t;

  typedef struct packed {
    logic                  valid;
    logic                  trap;
    logic [XLEN-1:0]       pc;
    logic [ILEN-1:0]       insn;
    logic [GPR_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       rd_wdata;
  } retire_t;

endpackage
